// ==== Bender.yml ====
package:
  name: ibuffer

sources:
  - corep_pkg.sv
  - distram_1rport_1wport.sv
  - fmid_tracker.sv
  - refill_beat_counter.sv
  - restart_drain_fsm.sv
  - ibuffer.sv
  - ibuffer_top.sv
  - target: test
    files:
      - ibuffer_properties.sv
      - tb_ibuffer.sv

// ==== corep_pkg.sv ====
// core front end package with instruction buffer sizes and the fetch block type

package corep_pkg;

    // ----------------------------------------------------------------------
    // instruction buffer sizing
    // ----------------------------------------------------------------------

    localparam int IBUFFER_ENTRIES = 8;
    localparam int IBUFFER_IDX_WIDTH = 3;

    // per-entry info is just the fetch pc
    localparam int INFO_WIDTH = 32;

    // ----------------------------------------------------------------------
    // fetch miss ids
    // ----------------------------------------------------------------------

    localparam int FMID_COUNT = 4;
    localparam int FMID_WIDTH = 2;

    // ----------------------------------------------------------------------
    // fetch block layout
    // ----------------------------------------------------------------------

    // 16-bit parcels per block
    localparam int FETCH_LANES = 8;

    // 32-bit beats per miss return
    localparam int REFILL_BEATS = 4;

    // drain state machine encoding
    localparam logic FSM_RUN = 1'b0;
    localparam logic FSM_DRAIN = 1'b1;

    // one 16 byte fetch block
    // refill writes it by word, marker decode reads it by parcel
    // index 0 is the lowest address in both views
    typedef union packed {
        logic [FETCH_LANES-1:0][15:0] parcel;
        logic [REFILL_BEATS-1:0][31:0] word;
    } fetch16B_t;

endpackage

// ==== distram_1rport_1wport.sv ====
// distributed RAM with one asynchronous read port and one synchronous write port

`timescale 1ns/1ps

module distram_1rport_1wport #(
    parameter int INNER_WIDTH = 32,
    parameter int OUTER_WIDTH = 8
) (
    input  logic                           CLK,
    input  logic [$clog2(OUTER_WIDTH)-1:0] rindex,
    output logic [INNER_WIDTH-1:0]         rdata,
    input  logic                           wen,
    input  logic [$clog2(OUTER_WIDTH)-1:0] windex,
    input  logic [INNER_WIDTH-1:0]         wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // read is visible in the same cycle
    assign rdata = mem[rindex];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[windex] <= wdata;
        end
    end

endmodule

// ==== fmid_tracker.sv ====
// free list of fetch-miss ids, hands out the lowest free id and takes back finished ones

`timescale 1ns/1ps

module fmid_tracker import corep_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  new_id_consume,
    output logic                  new_id_ready,
    output logic [FMID_WIDTH-1:0] new_id,
    input  logic                  old_id_done,
    input  logic [FMID_WIDTH-1:0] old_id,
    output logic                  all_free
);

    // one bit per id, set while a miss is outstanding
    logic [FMID_COUNT-1:0] in_use;

    // lowest free id wins
    always_comb begin
        new_id = '0;
        for (int i = FMID_COUNT - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                new_id = FMID_WIDTH'(i);
            end
        end
    end

    assign new_id_ready = ~&in_use;
    assign all_free = ~|in_use;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            in_use <= '0;
        end
        else begin
            // freed id is never the one handed out this cycle
            if (old_id_done) begin
                in_use[old_id] <= 1'b0;
            end
            if (new_id_consume) begin
                in_use[new_id] <= 1'b1;
            end
        end
    end

endmodule

// ==== ibuffer.sv ====
// circular instruction buffer with per-entry miss tracking and start-marker decode

`timescale 1ns/1ps

module ibuffer import corep_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   enq_valid,
    input  logic [INFO_WIDTH-1:0]  enq_pc,
    input  logic                   enq_fetch_hit_valid,
    input  fetch16B_t              enq_fetch_hit_data,
    input  logic                   enq_allow,
    output logic                   enq_ready,
    output logic [FMID_WIDTH-1:0]  enq_fmid,
    input  logic                   fill_valid,
    input  logic [FMID_WIDTH-1:0]  fill_fmid,
    input  fetch16B_t              fill_data,
    input  logic                   new_id_ready,
    input  logic [FMID_WIDTH-1:0]  new_id,
    output logic                   new_id_consume,
    output logic                   deq_valid,
    output logic [INFO_WIDTH-1:0]  deq_pc,
    output fetch16B_t              deq_data,
    output logic [FETCH_LANES-1:0] deq_start_markers,
    input  logic                   deq_ready,
    input  logic                   restart_valid
);

    logic [IBUFFER_IDX_WIDTH-1:0] enq_ptr;
    logic [IBUFFER_IDX_WIDTH-1:0] deq_ptr;
    logic [IBUFFER_IDX_WIDTH-1:0] enq_ptr_plus_1;
    logic [IBUFFER_IDX_WIDTH-1:0] deq_ptr_plus_1;
    logic                         full;
    logic                         empty;
    logic                         enq_fire;
    logic                         deq_fire;
    logic                         hit_fill;

    logic [IBUFFER_ENTRIES-1:0]                 miss_pending;
    logic [IBUFFER_ENTRIES-1:0][FMID_WIDTH-1:0] miss_fmid;
    logic [IBUFFER_ENTRIES-1:0]                 match_vec;
    logic                                       miss_fill_valid;
    logic [IBUFFER_IDX_WIDTH-1:0]               miss_fill_idx;

    logic                         instr_wen;
    logic [IBUFFER_IDX_WIDTH-1:0] instr_windex;
    fetch16B_t                    instr_wdata;

    // ----------------------------------------------------------------------
    // handshakes
    // ----------------------------------------------------------------------

    // a hit needs the write port, a miss needs a free id
    assign enq_ready = enq_allow & ~restart_valid & ~full
                     & (enq_fetch_hit_valid ? ~miss_fill_valid : new_id_ready);
    assign enq_fmid = new_id;
    assign enq_fire = enq_valid & enq_ready;
    assign new_id_consume = enq_fire & ~enq_fetch_hit_valid;
    assign hit_fill = enq_fire & enq_fetch_hit_valid;

    // head must exist and hold its data
    assign deq_valid = ~empty & ~miss_pending[deq_ptr];
    assign deq_fire = deq_valid & deq_ready;

    // entry count is a power of two, so pointers wrap on their own
    assign enq_ptr_plus_1 = enq_ptr + 1'b1;
    assign deq_ptr_plus_1 = deq_ptr + 1'b1;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end
        else if (restart_valid) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
            full <= 1'b0;
            empty <= 1'b1;
        end
        else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr_plus_1;
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr_plus_1;
            end
            if (enq_fire && !deq_fire) begin
                empty <= 1'b0;
                full <= (enq_ptr_plus_1 == deq_ptr);
            end
            if (deq_fire && !enq_fire) begin
                full <= 1'b0;
                empty <= (deq_ptr_plus_1 == enq_ptr);
            end
        end
    end

    // ----------------------------------------------------------------------
    // miss tracking and fill match
    // ----------------------------------------------------------------------

    always_comb begin
        for (int i = 0; i < IBUFFER_ENTRIES; i++) begin
            match_vec[i] = fill_valid & miss_pending[i] & (miss_fmid[i] == fill_fmid);
        end
    end

    // lowest matching entry, at most one in practice
    always_comb begin
        miss_fill_idx = '0;
        for (int i = IBUFFER_ENTRIES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                miss_fill_idx = IBUFFER_IDX_WIDTH'(i);
            end
        end
    end

    assign miss_fill_valid = |match_vec;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            miss_pending <= '0;
        end
        else if (restart_valid) begin
            miss_pending <= '0;
        end
        else begin
            if (enq_fire) begin
                miss_pending[enq_ptr] <= ~enq_fetch_hit_valid;
            end
            if (miss_fill_valid) begin
                miss_pending[miss_fill_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            miss_fmid[enq_ptr] <= new_id;
        end
    end

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    // miss fill owns the write port, hits are refused that cycle
    assign instr_wen = miss_fill_valid | hit_fill;
    assign instr_windex = miss_fill_valid ? miss_fill_idx : enq_ptr;
    assign instr_wdata = miss_fill_valid ? fill_data : enq_fetch_hit_data;

    distram_1rport_1wport #(
        .INNER_WIDTH(INFO_WIDTH),
        .OUTER_WIDTH(IBUFFER_ENTRIES)
    ) info_distram (
        .CLK(CLK),
        .rindex(deq_ptr),
        .rdata(deq_pc),
        .wen(enq_fire),
        .windex(enq_ptr),
        .wdata(enq_pc)
    );

    distram_1rport_1wport #(
        .INNER_WIDTH($bits(fetch16B_t)),
        .OUTER_WIDTH(IBUFFER_ENTRIES)
    ) instr_distram (
        .CLK(CLK),
        .rindex(deq_ptr),
        .rdata(deq_data),
        .wen(instr_wen),
        .windex(instr_windex),
        .wdata(instr_wdata)
    );

    // ----------------------------------------------------------------------
    // start markers
    // ----------------------------------------------------------------------

    // a start parcel ending in 2'b11 is 32-bit, so the next parcel continues it
    always_comb begin
        logic is_start;
        is_start = 1'b1;
        for (int i = 0; i < FETCH_LANES; i++) begin
            deq_start_markers[i] = is_start;
            is_start = ~(is_start & (deq_data.parcel[i][1:0] == 2'b11));
        end
    end

endmodule

// ==== ibuffer_properties.sv ====
// concurrent assertions on instruction buffer handshakes, refill beats and fmid use

`timescale 1ns/1ps

module ibuffer_properties import corep_pkg::*; (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  enq_ready,
    input logic [FMID_WIDTH-1:0] enq_fmid,
    input logic                  new_id_consume,
    input logic                  refill_valid,
    input logic [FMID_WIDTH-1:0] refill_fmid,
    input logic                  fill_valid,
    input logic [FMID_WIDTH-1:0] fill_fmid,
    input logic                  deq_valid,
    input logic                  deq_ready,
    input logic [INFO_WIDTH-1:0] deq_pc,
    input fetch16B_t             deq_data,
    input logic                  restart_valid
);

    // ids handed out and not yet returned
    logic [FMID_COUNT-1:0] issued;

    // restart with ids still out, until the cycle after the last one returns
    logic draining;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issued <= '0;
        end
        else begin
            if (fill_valid) begin
                issued[fill_fmid] <= 1'b0;
            end
            if (new_id_consume) begin
                issued[enq_fmid] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            draining <= 1'b0;
        end
        else if (restart_valid && |issued) begin
            draining <= 1'b1;
        end
        else if (issued == '0) begin
            draining <= 1'b0;
        end
    end

    // head only moves with a handshake
    deq_hold: assert property (@(posedge CLK) disable iff (!nRST)
        deq_valid && !deq_ready && !restart_valid
        |=> deq_valid && $stable(deq_pc) && $stable(deq_data))
        else $error("dequeue head moved without deq_valid and deq_ready");

    refill_same_fmid: assert property (@(posedge CLK) disable iff (!nRST)
        refill_valid && !fill_valid |=> refill_valid && refill_fmid == $past(refill_fmid))
        else $error("refill beats of one miss broke up or changed fmid");

    drain_blocks_enq: assert property (@(posedge CLK) disable iff (!nRST)
        draining |-> !enq_ready)
        else $error("enq_ready high while draining");

    fmid_not_reused: assert property (@(posedge CLK) disable iff (!nRST)
        new_id_consume |-> !issued[enq_fmid])
        else $error("enq_fmid handed out while still in use");

endmodule

bind ibuffer_top ibuffer_properties u_ibuffer_properties (.*);

// ==== ibuffer_top.sv ====
// instruction buffer subsystem top with id tracker, refill assembly and restart drain

`timescale 1ns/1ps

module ibuffer_top import corep_pkg::*; (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   enq_valid,
    input  logic [INFO_WIDTH-1:0]  enq_pc,
    input  logic                   enq_fetch_hit_valid,
    input  fetch16B_t              enq_fetch_hit_data,
    output logic                   enq_ready,
    output logic [FMID_WIDTH-1:0]  enq_fmid,
    input  logic                   refill_valid,
    input  logic [FMID_WIDTH-1:0]  refill_fmid,
    input  logic [31:0]            refill_word,
    output logic                   deq_valid,
    output logic [INFO_WIDTH-1:0]  deq_pc,
    output fetch16B_t              deq_data,
    output logic [FETCH_LANES-1:0] deq_start_markers,
    input  logic                   deq_ready,
    input  logic                   restart_valid
);

    logic                  enq_allow;
    logic                  all_free;
    logic                  fill_valid;
    logic [FMID_WIDTH-1:0] fill_fmid;
    fetch16B_t             fill_data;
    logic                  new_id_ready;
    logic [FMID_WIDTH-1:0] new_id;
    logic                  new_id_consume;

    ibuffer u_ibuffer (
        .CLK(CLK),
        .nRST(nRST),
        .enq_valid(enq_valid),
        .enq_pc(enq_pc),
        .enq_fetch_hit_valid(enq_fetch_hit_valid),
        .enq_fetch_hit_data(enq_fetch_hit_data),
        .enq_allow(enq_allow),
        .enq_ready(enq_ready),
        .enq_fmid(enq_fmid),
        .fill_valid(fill_valid),
        .fill_fmid(fill_fmid),
        .fill_data(fill_data),
        .new_id_ready(new_id_ready),
        .new_id(new_id),
        .new_id_consume(new_id_consume),
        .deq_valid(deq_valid),
        .deq_pc(deq_pc),
        .deq_data(deq_data),
        .deq_start_markers(deq_start_markers),
        .deq_ready(deq_ready),
        .restart_valid(restart_valid)
    );

    // ids come back with the last refill beat, even while draining
    fmid_tracker u_fmid_tracker (
        .CLK(CLK),
        .nRST(nRST),
        .new_id_consume(new_id_consume),
        .new_id_ready(new_id_ready),
        .new_id(new_id),
        .old_id_done(fill_valid),
        .old_id(fill_fmid),
        .all_free(all_free)
    );

    refill_beat_counter u_refill_beat_counter (
        .CLK(CLK),
        .nRST(nRST),
        .refill_valid(refill_valid),
        .refill_fmid(refill_fmid),
        .refill_word(refill_word),
        .fill_valid(fill_valid),
        .fill_fmid(fill_fmid),
        .fill_data(fill_data)
    );

    restart_drain_fsm u_restart_drain_fsm (
        .CLK(CLK),
        .nRST(nRST),
        .restart_valid(restart_valid),
        .all_free(all_free),
        .enq_allow(enq_allow)
    );

endmodule

// ==== refill_beat_counter.sv ====
// collects the four 32-bit beats of a miss return into one fetch block

`timescale 1ns/1ps

module refill_beat_counter import corep_pkg::*; (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  refill_valid,
    input  logic [FMID_WIDTH-1:0] refill_fmid,
    input  logic [31:0]           refill_word,
    output logic                  fill_valid,
    output logic [FMID_WIDTH-1:0] fill_fmid,
    output fetch16B_t             fill_data
);

    localparam int BEAT_WIDTH = $clog2(REFILL_BEATS);

    logic [BEAT_WIDTH-1:0] beat_cnt;
    logic                  last_beat;

    // words of the current miss seen so far
    fetch16B_t hold_block;

    assign last_beat = (beat_cnt == BEAT_WIDTH'(REFILL_BEATS - 1));

    // ----------------------------------------------------------------------
    // beat count and holding block
    // ----------------------------------------------------------------------

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            beat_cnt <= '0;
        end
        else if (refill_valid) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (refill_valid) begin
            hold_block.word[beat_cnt] <= refill_word;
        end
    end

    // ----------------------------------------------------------------------
    // fill goes out together with the last beat
    // ----------------------------------------------------------------------

    assign fill_valid = refill_valid & last_beat;
    assign fill_fmid = refill_fmid;

    always_comb begin
        fill_data = hold_block;
        fill_data.word[REFILL_BEATS-1] = refill_word;
    end

endmodule

// ==== restart_drain_fsm.sv ====
// holds off enqueue after a restart until all outstanding misses have returned

`timescale 1ns/1ps

module restart_drain_fsm import corep_pkg::*; (
    input  logic CLK,
    input  logic nRST,
    input  logic restart_valid,
    input  logic all_free,
    output logic enq_allow
);

    logic state;
    logic state_next;

    always_comb begin
        state_next = state;
        case (state)
            FSM_RUN: begin
                // nothing in flight means no need to drain
                if (restart_valid && !all_free) begin
                    state_next = FSM_DRAIN;
                end
            end
            FSM_DRAIN: begin
                if (all_free) begin
                    state_next = FSM_RUN;
                end
            end
            default: state_next = FSM_RUN;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= FSM_RUN;
        end
        else begin
            state <= state_next;
        end
    end

    assign enq_allow = (state == FSM_RUN);

endmodule

// ==== sources.f ====
corep_pkg.sv
distram_1rport_1wport.sv
fmid_tracker.sv
refill_beat_counter.sv
restart_drain_fsm.sv
ibuffer.sv
ibuffer_top.sv
ibuffer_properties.sv
tb_ibuffer.sv

// ==== tb_ibuffer.sv ====
// testbench for the instruction buffer subsystem, table driven against a reference queue

`timescale 1ns/1ps

module tb_ibuffer import corep_pkg::*; ();

    localparam logic [3:0] OP_HIT = 4'd0;
    localparam logic [3:0] OP_MISS = 4'd1;
    localparam logic [3:0] OP_REFILL = 4'd2;
    localparam logic [3:0] OP_RESTART = 4'd3;
    localparam logic [3:0] OP_STALL = 4'd4;
    localparam logic [3:0] OP_DEQ = 4'd5;
    localparam int NUM_STEPS = 41;
    localparam int STEP_BUDGET = 40;

    logic                   CLK;
    logic                   nRST;
    logic                   enq_valid;
    logic [INFO_WIDTH-1:0]  enq_pc;
    logic                   enq_fetch_hit_valid;
    fetch16B_t              enq_fetch_hit_data;
    logic                   enq_ready;
    logic [FMID_WIDTH-1:0]  enq_fmid;
    logic                   refill_valid;
    logic [FMID_WIDTH-1:0]  refill_fmid;
    logic [31:0]            refill_word;
    logic                   deq_valid;
    logic [INFO_WIDTH-1:0]  deq_pc;
    fetch16B_t              deq_data;
    logic [FETCH_LANES-1:0] deq_start_markers;
    logic                   deq_ready;
    logic                   restart_valid;

    // step word is {op, arg, unused, expected enq_ready}
    logic [15:0] steps [NUM_STEPS];
    logic [31:0] lfsr_state;
    logic [31:0] next_pc;

    // reference queue, one element per buffer entry
    logic [INFO_WIDTH-1:0] q_pc [$];
    logic [127:0]          q_data [$];
    logic                  q_pend [$];
    int                    q_fmid [$];
    logic [FMID_COUNT-1:0] fmid_busy;

    ibuffer_top u_dut (
        .CLK(CLK),
        .nRST(nRST),
        .enq_valid(enq_valid),
        .enq_pc(enq_pc),
        .enq_fetch_hit_valid(enq_fetch_hit_valid),
        .enq_fetch_hit_data(enq_fetch_hit_data),
        .enq_ready(enq_ready),
        .enq_fmid(enq_fmid),
        .refill_valid(refill_valid),
        .refill_fmid(refill_fmid),
        .refill_word(refill_word),
        .deq_valid(deq_valid),
        .deq_pc(deq_pc),
        .deq_data(deq_data),
        .deq_start_markers(deq_start_markers),
        .deq_ready(deq_ready),
        .restart_valid(restart_valid)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    function automatic logic [15:0] step(input logic [3:0] op, input int arg, input logic exp);
        return {op, arg[7:0], 3'b000, exp};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic get_random_block(output logic [127:0] blk);
        for (int i = 0; i < 128; i++) begin
            blk[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // walk the parcels, a 32-bit start skips its upper half
    function automatic logic [7:0] expected_markers(input logic [127:0] blk);
        logic [7:0] m;
        int p;
        m = '0;
        p = 0;
        while (p < FETCH_LANES) begin
            m[p] = 1'b1;
            p = (blk[16*p +: 2] == 2'b11) ? p + 2 : p + 1;
        end
        return m;
    endfunction

    function automatic int lowest_free_fmid();
        for (int i = 0; i < FMID_COUNT; i++) begin
            if (!fmid_busy[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_head();
        logic exp_valid;
        exp_valid = (q_pc.size() > 0) && !q_pend[0];
        check("deq_valid", deq_valid, exp_valid);
        if (exp_valid) begin
            check("deq_pc", deq_pc, q_pc[0]);
            check("deq_data", deq_data, q_data[0]);
            check("deq_start_markers", deq_start_markers, expected_markers(q_data[0]));
        end
    endtask

    // ----------------------------------------------------------------------
    // operations
    // ----------------------------------------------------------------------

    task automatic enqueue(input logic hit, input logic exp_ready);
        logic [127:0] blk;
        int fmid;
        get_random_block(blk);
        fmid = lowest_free_fmid();
        @(posedge CLK);
        enq_valid <= 1'b1;
        enq_pc <= next_pc;
        enq_fetch_hit_valid <= hit;
        enq_fetch_hit_data <= blk;
        @(negedge CLK);
        check("enq_ready", enq_ready, exp_ready);
        if (exp_ready) begin
            q_pc.push_back(next_pc);
            q_data.push_back(blk);
            q_pend.push_back(!hit);
            q_fmid.push_back(fmid);
            if (!hit) begin
                check("enq_fmid", enq_fmid, fmid);
                fmid_busy[fmid] = 1'b1;
            end
        end
        next_pc = next_pc + 32'd16;
        @(posedge CLK);
        enq_valid <= 1'b0;
    endtask

    task automatic refill(input int fmid);
        logic [127:0] blk;
        int idx;
        idx = -1;
        // flushed entries get throwaway data
        get_random_block(blk);
        for (int i = q_pend.size() - 1; i >= 0; i--) begin
            if (q_pend[i] && q_fmid[i] == fmid) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            blk = q_data[idx];
        end
        for (int b = 0; b < REFILL_BEATS; b++) begin
            @(posedge CLK);
            refill_valid <= 1'b1;
            refill_fmid <= FMID_WIDTH'(fmid);
            refill_word <= blk[32*b +: 32];
        end
        @(posedge CLK);
        refill_valid <= 1'b0;
        if (idx >= 0) begin
            q_pend[idx] = 1'b0;
        end
        fmid_busy[fmid] = 1'b0;
    endtask

    task automatic dequeue(input int n);
        repeat (n) begin
            @(negedge CLK);
            while (!deq_valid) begin
                @(negedge CLK);
            end
            check_head();
            @(posedge CLK);
            deq_ready <= 1'b1;
            @(posedge CLK);
            deq_ready <= 1'b0;
            void'(q_pc.pop_front());
            void'(q_data.pop_front());
            void'(q_pend.pop_front());
            void'(q_fmid.pop_front());
        end
    endtask

    task automatic stall(input int n);
        repeat (n) begin
            @(negedge CLK);
            check_head();
        end
    endtask

    task automatic restart(input logic exp_ready);
        @(posedge CLK);
        restart_valid <= 1'b1;
        @(posedge CLK);
        restart_valid <= 1'b0;
        q_pc.delete();
        q_data.delete();
        q_pend.delete();
        q_fmid.delete();
        @(negedge CLK);
        check_head();
        check("enq_ready", enq_ready, exp_ready);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [3:0] op;
        int arg;
        logic exp_bit;
        steps = '{
            step(OP_HIT, 3, 1),
            step(OP_DEQ, 3, 0),
            step(OP_MISS, 1, 1),
            step(OP_STALL, 3, 0),
            step(OP_REFILL, 0, 0),
            step(OP_DEQ, 1, 0),
            // out of order return, the filled entry waits behind the miss
            step(OP_MISS, 2, 1),
            step(OP_HIT, 1, 1),
            step(OP_REFILL, 1, 0),
            step(OP_STALL, 2, 0),
            step(OP_REFILL, 0, 0),
            step(OP_DEQ, 3, 0),
            step(OP_HIT, 8, 1),
            step(OP_HIT, 1, 0),
            step(OP_STALL, 4, 0),
            step(OP_DEQ, 8, 0),
            // all ids out, misses refused but hits pass
            step(OP_MISS, 4, 1),
            step(OP_MISS, 1, 0),
            step(OP_HIT, 1, 1),
            step(OP_REFILL, 2, 0),
            step(OP_REFILL, 0, 0),
            step(OP_REFILL, 3, 0),
            step(OP_REFILL, 1, 0),
            step(OP_DEQ, 5, 0),
            step(OP_MISS, 2, 1),
            step(OP_HIT, 1, 1),
            step(OP_RESTART, 0, 0),
            step(OP_STALL, 2, 0),
            step(OP_HIT, 1, 0),
            step(OP_REFILL, 1, 0),
            step(OP_REFILL, 0, 0),
            step(OP_HIT, 1, 1),
            step(OP_MISS, 1, 1),
            step(OP_REFILL, 0, 0),
            step(OP_DEQ, 2, 0),
            step(OP_RESTART, 0, 1),
            step(OP_HIT, 1, 1),
            step(OP_DEQ, 1, 0),
            step(OP_HIT, 2, 1),
            step(OP_STALL, 1, 0),
            step(OP_DEQ, 2, 0)
        };
        lfsr_state = 32'h1916;
        next_pc = 32'h8000_0000;
        fmid_busy = '0;
        nRST = 1'b0;
        enq_valid = 1'b0;
        enq_pc = '0;
        enq_fetch_hit_valid = 1'b0;
        enq_fetch_hit_data = '0;
        refill_valid = 1'b0;
        refill_fmid = '0;
        refill_word = '0;
        deq_ready = 1'b0;
        restart_valid = 1'b0;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_head();
        check("enq_ready", enq_ready, 1'b1);
        for (int s = 0; s < NUM_STEPS; s++) begin
            op = steps[s][15:12];
            arg = int'(steps[s][11:4]);
            exp_bit = steps[s][0];
            case (op)
                OP_HIT: repeat (arg) enqueue(1'b1, exp_bit);
                OP_MISS: repeat (arg) enqueue(1'b0, exp_bit);
                OP_REFILL: refill(arg);
                OP_RESTART: restart(exp_bit);
                OP_STALL: stall(arg);
                default: dequeue(arg);
            endcase
        end
        @(negedge CLK);
        check_head();
        $display("NO ERRORS");
        $finish;
    end

    // reset plus a fixed cycle budget per table step
    initial begin
        repeat (8 + NUM_STEPS * STEP_BUDGET) @(posedge CLK);
        fail_run("timeout: the test steps did not complete within the cycle budget");
    end

endmodule
